/* hdl/rs5_pkg.sv */
//////////////////////////////////////////////////////////////////////
// shared types for the rv32i execute slice.
// data word, register index and instruction word types,
// rv32i major opcodes, register count and the alu operation enum.
//////////////////////////////////////////////////////////////////////

`default_nettype none

package rs5_pkg;

    // widths with a meaning of their own.
    typedef logic [31:0] word_t;      // register contents, operands, results.
    typedef logic [4:0]  reg_addr_t;  // register index, x0..x31.
    typedef logic [31:0] instr_t;     // raw instruction word.

    // number of architectural registers.
    localparam int NUM_REGS = 32;

    // rv32i major opcodes, bits 6:0 of the instruction.
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;  // register-register.
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;  // register-immediate.
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;  // load upper immediate.

    // operations the alu knows.
    // encoding follows funct3 order for the base set, pass_b sits on top.
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10   // operand b straight through, for lui.
    } alu_op_e;

endpackage

`default_nettype wire

/* hdl/exec_if.sv */
//////////////////////////////////////////////////////////////////////
// decoder to execute stage connection.
// one-cycle valid strobe qualifies op, rd and both operands.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface exec_if
    import rs5_pkg::*;
();

    logic      valid;      // one strobe per decoded instruction.
    alu_op_e   op;         // what the alu should do.
    reg_addr_t rd;         // destination register.
    word_t     operand_a;  // rs1 value, forwarded when needed.
    word_t     operand_b;  // rs2 value or immediate.

    // decoder side, everything is driven from registers.
    modport decode_mp (output valid, op, rd, operand_a, operand_b);

    // execute side only reads.
    modport execute_mp (input valid, op, rd, operand_a, operand_b);

endinterface

`default_nettype wire

/* hdl/regbank.sv */
//////////////////////////////////////////////////////////////////////
// register bank, 32 registers of 32 bits.
// two combinational read ports, one synchronous write port.
// x0 is a constant zero.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module regbank
    import rs5_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset,

    input  wire reg_addr_t rs1_i,     // read port 1 index.
    input  wire reg_addr_t rs2_i,     // read port 2 index.
    input  wire reg_addr_t rd_i,      // write index.
    input  wire logic      enable_i,  // write strobe.
    input  wire word_t     data_i,    // write data.
    output      word_t     data1_o,   // read port 1 data.
    output      word_t     data2_o    // read port 2 data.
);

    word_t regfile [NUM_REGS];

    // x0 never stores anything, so writes aimed at it vanish here.
    assign regfile[0] = '0;

    // reads are plain muxes on the array.
    assign data1_o = regfile[rs1_i];
    assign data2_o = regfile[rs2_i];

    // one write decoder per register, x1 and up.
    for (genvar i = 1; i < NUM_REGS; i++) begin : gen_regfile
        always_ff @(posedge clk) begin
            if (reset) begin
                regfile[i] <= '0;                   // all registers read zero after reset.
            end else if (enable_i && rd_i == reg_addr_t'(i)) begin
                regfile[i] <= data_i;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/decoder.sv */
//////////////////////////////////////////////////////////////////////
// instruction decoder for the op, op-imm and lui groups.
// field extraction, immediates, alu op mapping, operand forwarding
// from execute, illegal detection and the decode pipeline register.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module decoder
    import rs5_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset,

    input  wire logic      instr_valid_i,  // one-cycle instruction strobe.
    input  wire instr_t    instr_i,

    output      reg_addr_t rf_rs1_o,       // regbank read addresses.
    output      reg_addr_t rf_rs2_o,
    input  wire word_t     rf_data1_i,     // regbank read data.
    input  wire word_t     rf_data2_i,
    input  wire word_t     fwd_result_i,   // alu result of the instruction in execute.

    output      logic      illegal_o,      // pulse for an unsupported opcode.

    exec_if.decode_mp      ex
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;           // funct7 bit 5 (instruction bit 30).
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    word_t      imm_i;
    word_t      imm_u;
    word_t      shamt;
    word_t      src1;
    word_t      src2;
    logic       legal;
    alu_op_e    alu_op;
    word_t      op_a;
    word_t      op_b;

    // funct3 to alu op mapping shared by op and op-imm.
    // alt_ok is low for op-imm so addi never turns into a sub.
    function automatic alu_op_e map_funct(input logic [2:0] f3, input logic alt_bit,
                                          input logic alt_ok);
        alu_op_e op;
        case (f3)
            3'b000:  op = (alt_bit && alt_ok) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt_bit ? ALU_SRA : ALU_SRL;   // srai also carries bit 30.
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // fixed rv32i field positions.
    assign opcode = instr_i[6:0];
    assign rd     = instr_i[11:7];
    assign funct3 = instr_i[14:12];
    assign rs1    = instr_i[19:15];
    assign rs2    = instr_i[24:20];
    assign alt    = instr_i[30];

    // immediates.
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};   // sign extended i-type.
    assign imm_u = {instr_i[31:12], 12'b0};               // u-type for lui.
    assign shamt = {27'b0, instr_i[24:20]};               // shift amount in the low five bits.

    assign rf_rs1_o = rs1;
    assign rf_rs2_o = rs2;

    // the execute result bypasses the bank it has not reached yet.
    // x0 never forwards since its write is dropped.
    assign src1 = (ex.valid && ex.rd != '0 && ex.rd == rs1) ? fwd_result_i : rf_data1_i;
    assign src2 = (ex.valid && ex.rd != '0 && ex.rd == rs2) ? fwd_result_i : rf_data2_i;

    // decode.
    always_comb begin
        legal  = 1'b1;
        alu_op = ALU_ADD;
        op_a   = src1;
        op_b   = src2;
        case (opcode)
            OPCODE_OP: begin
                alu_op = map_funct(funct3, alt, 1'b1);
            end
            OPCODE_OP_IMM: begin
                alu_op = map_funct(funct3, alt, 1'b0);
                // shifts take the rs2 field as amount and the rest the full immediate.
                op_b   = (funct3 == 3'b001 || funct3 == 3'b101) ? shamt : imm_i;
            end
            OPCODE_LUI: begin
                alu_op = ALU_PASS_B;
                op_a   = '0;            // rs1 bits belong to the immediate here.
                op_b   = imm_u;
            end
            default: begin
                legal = 1'b0;           // anything else is a no-op with a flag.
            end
        endcase
    end

    // control half of the pipeline register.
    always_ff @(posedge clk) begin
        if (reset) begin
            ex.valid  <= 1'b0;
            illegal_o <= 1'b0;
        end else begin
            ex.valid  <= instr_valid_i && legal;
            illegal_o <= instr_valid_i && !legal;
        end
    end

    // payload half is only meaningful under ex.valid.
    always_ff @(posedge clk) begin
        if (instr_valid_i) begin
            ex.op        <= alu_op;
            ex.rd        <= rd;
            ex.operand_a <= op_a;
            ex.operand_b <= op_b;
        end
    end

endmodule

`default_nettype wire

/* hdl/execute.sv */
//////////////////////////////////////////////////////////////////////
// execute stage.
// combinational alu on the decoded operands and a registered
// writeback report of valid, rd and result.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module execute
    import rs5_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset,

    exec_if.execute_mp     ex,

    output      word_t     result_o,    // alu output, to bank and forwarding.
    output      logic      wb_valid_o,  // write report, one cycle after execute.
    output      reg_addr_t wb_rd_o,
    output      word_t     wb_data_o
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = ex.operand_b[4:0];   // shifts only look at five bits.
    assign lt_signed   = $signed(ex.operand_a) < $signed(ex.operand_b);
    assign lt_unsigned = ex.operand_a < ex.operand_b;

    // alu.
    always_comb begin
        case (ex.op)
            ALU_ADD:    result_o = ex.operand_a + ex.operand_b;
            ALU_SUB:    result_o = ex.operand_a - ex.operand_b;
            ALU_SLL:    result_o = ex.operand_a << shamt;
            ALU_SLT:    result_o = {31'b0, lt_signed};
            ALU_SLTU:   result_o = {31'b0, lt_unsigned};
            ALU_XOR:    result_o = ex.operand_a ^ ex.operand_b;
            ALU_SRL:    result_o = ex.operand_a >> shamt;
            ALU_SRA:    result_o = word_t'($signed(ex.operand_a) >>> shamt);   // sign fill.
            ALU_OR:     result_o = ex.operand_a | ex.operand_b;
            ALU_AND:    result_o = ex.operand_a & ex.operand_b;
            ALU_PASS_B: result_o = ex.operand_b;     // lui.
            default:    result_o = '0;
        endcase
    end

    // writeback report, mirrors the bank write of the same edge.
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= ex.valid;
        end
    end

    // report payload.
    always_ff @(posedge clk) begin
        if (ex.valid) begin
            wb_rd_o   <= ex.rd;      // rd 0 is reported even though the bank drops it.
            wb_data_o <= result_o;
        end
    end

endmodule

`default_nettype wire

/* hdl/rs5_exec_top.sv */
//////////////////////////////////////////////////////////////////////
// top level of the execute slice.
// decoder, register bank and execute stage, joined by exec_if
// and the bank read, write and forwarding wires.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rs5_exec_top
    import rs5_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset,

    input  wire logic      instr_valid_i,  // one instruction per strobe.
    input  wire instr_t    instr_i,

    output      logic      illegal_o,      // unsupported opcode seen.
    output      logic      wb_valid_o,     // register write report.
    output      reg_addr_t wb_rd_o,
    output      word_t     wb_data_o
);

    reg_addr_t rf_rs1;
    reg_addr_t rf_rs2;
    word_t     rf_data1;
    word_t     rf_data2;
    word_t     result;      // execute result, written back and forwarded.

    exec_if i_exec_if ();

    decoder i_decoder (
        .clk           (clk),
        .reset         (reset),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rf_rs1_o      (rf_rs1),
        .rf_rs2_o      (rf_rs2),
        .rf_data1_i    (rf_data1),
        .rf_data2_i    (rf_data2),
        .fwd_result_i  (result),
        .illegal_o     (illegal_o),
        .ex            (i_exec_if)
    );

    // the bank writes whatever execute holds under a valid strobe.
    regbank i_regbank (
        .clk      (clk),
        .reset    (reset),
        .rs1_i    (rf_rs1),
        .rs2_i    (rf_rs2),
        .rd_i     (i_exec_if.rd),
        .enable_i (i_exec_if.valid),
        .data_i   (result),
        .data1_o  (rf_data1),
        .data2_o  (rf_data2)
    );

    execute i_execute (
        .clk        (clk),
        .reset      (reset),
        .ex         (i_exec_if),
        .result_o   (result),
        .wb_valid_o (wb_valid_o),
        .wb_rd_o    (wb_rd_o),
        .wb_data_o  (wb_data_o)
    );

endmodule

`default_nettype wire

/* verif/rs5_exec_asserts.sv */
//////////////////////////////////////////////////////////////////////
// concurrent checks on the execute slice top level.
// quiet outputs in reset, no write after an illegal pulse,
// write reports only where an instruction strobe came before.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rs5_exec_asserts (
    input wire logic clk,
    input wire logic reset,
    input wire logic instr_valid_i,
    input wire logic illegal_i,
    input wire logic wb_valid_i
);

    int failures = 0;   // count of failed assertions.

    // outputs go low one edge into reset and stay low.
    a_reset_quiet: assert property (@(posedge clk) reset |=> !illegal_i && !wb_valid_i)
        else begin
            failures++;
            $error("illegal or write report during reset");
        end

    // an illegal instruction never reaches the bank.
    a_illegal_no_write: assert property (@(posedge clk) disable iff (reset)
        illegal_i |=> !wb_valid_i)
        else begin
            failures++;
            $error("write report after an illegal pulse");
        end

    // decode and execute take two edges.
    a_write_after_strobe: assert property (@(posedge clk) disable iff (reset)
        wb_valid_i |-> $past(instr_valid_i, 2))
        else begin
            failures++;
            $error("write report without an instruction");
        end

endmodule

bind rs5_exec_top rs5_exec_asserts i_asserts (
    .clk           (clk),
    .reset         (reset),
    .instr_valid_i (instr_valid_i),
    .illegal_i     (illegal_o),
    .wb_valid_i    (wb_valid_o)
);

`default_nettype wire

/* verif/tb_rs5_exec.sv */
//////////////////////////////////////////////////////////////////////
// testbench for the rv32i execute slice.
// clock, reset, directed and random instruction stimulus,
// reference model, writeback compare process and timeout.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_rs5_exec
    import rs5_pkg::*;
();

    typedef struct packed {
        reg_addr_t rd;
        word_t     data;
    } wb_exp_t;

    logic      clk;
    logic      reset;
    logic      instr_valid;
    instr_t    instr;
    logic      illegal;
    logic      wb_valid;
    reg_addr_t wb_rd;
    word_t     wb_data;

    word_t     model [32];          // register state in program order.
    wb_exp_t   exp_q [$];           // expected write reports in issue order.
    logic      drive_legal = 1'b1;  // legality of the word on the bus.
    logic      exp_illegal = 1'b0;  // illegal_o expected this cycle.
    int        issued = 0;
    int        cycles = 0;
    integer    seed = 32'h62a9_0ca6;
    logic [11:0] imm_set [6] = '{12'h000, 12'h001, 12'h01f, 12'h7ff, 12'h800, 12'hfff};

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    rs5_exec_top i_dut (
        .clk           (clk),
        .reset         (reset),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .illegal_o     (illegal),
        .wb_valid_o    (wb_valid),
        .wb_rd_o       (wb_rd),
        .wb_data_o     (wb_data)
    );

    task automatic stop_run();
        $display("Done: errors found");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input word_t got, input word_t want);
        if (got !== want) begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, want);
            stop_run();
        end
    endtask

    // rv32i semantics for op, op-imm and lui taken from the isa rules.
    function automatic logic expected_result(input instr_t word, input word_t regs [32],
                                             output reg_addr_t rd, output word_t data);
        word_t a;
        word_t b;
        logic  is_op;
        logic  legal;
        rd    = word[11:7];
        is_op = (word[6:0] == OPCODE_OP);
        legal = is_op || word[6:0] == OPCODE_OP_IMM || word[6:0] == OPCODE_LUI;
        a     = regs[word[19:15]];
        b     = is_op ? regs[word[24:20]] : {{20{word[31]}}, word[31:20]};  // i-type imm.
        case (word[14:12])
            3'b000:  data = (is_op && word[30]) ? a - b : a + b;   // no subi in rv32i.
            3'b001:  data = a << b[4:0];
            3'b010:  data = {31'b0, $signed(a) < $signed(b)};
            3'b011:  data = {31'b0, a < b};
            3'b100:  data = a ^ b;
            3'b101:  data = word[30] ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  data = a | b;
            default: data = a & b;
        endcase
        if (word[6:0] == OPCODE_LUI) data = {word[31:12], 12'h000};
        return legal;
    endfunction

    function automatic instr_t encode_r(input logic [6:0] f7, input reg_addr_t rs2,
                                        input reg_addr_t rs1, input logic [2:0] f3,
                                        input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPCODE_OP};
    endfunction

    function automatic instr_t encode_i(input logic [11:0] imm, input reg_addr_t rs1,
                                        input logic [2:0] f3, input reg_addr_t rd);
        return {imm, rs1, f3, rd, OPCODE_OP_IMM};
    endfunction

    function automatic instr_t encode_u(input logic [19:0] imm, input reg_addr_t rd);
        return {imm, rd, OPCODE_LUI};
    endfunction

    // drives one instruction for one cycle and moves the model on at issue.
    task automatic issue(input instr_t word);
        reg_addr_t rd;
        word_t     data;
        logic      legal;
        wb_exp_t   e;
        legal = expected_result(word, model, rd, data);
        if (legal) begin
            e.rd   = rd;
            e.data = data;
            exp_q.push_back(e);
            if (rd != 5'd0) model[rd] = data;   // x0 keeps its zero.
        end
        instr_valid = 1'b1;
        instr       = word;
        drive_legal = legal;
        issued++;
        @(posedge clk);
        #2;
        instr_valid = 1'b0;
        drive_legal = 1'b1;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    // illegal pulse follows the sampling edge by one cycle.
    always @(posedge clk) begin
        exp_illegal <= instr_valid && !drive_legal;
        cycles      <= cycles + 1;
        if (cycles > 4 * issued + 100) begin
            $display("timeout: test did not finish within %0d cycles", cycles);
            stop_run();
        end
    end

    // outputs settle after the rising edge, so compare on the falling one.
    always @(negedge clk) begin : compare
        wb_exp_t e;
        if (!reset) begin
            if (i_dut.i_asserts.failures != 0) begin
                $display("a concurrent assertion on the DUT failed");
                stop_run();
            end
            check_value("illegal_o", word_t'(illegal), word_t'(exp_illegal));
            if (wb_valid) begin
                if (exp_q.size() == 0) begin
                    $display("write report to x%0d at %0t ns with nothing pending",
                             wb_rd, $time);
                    stop_run();
                end else begin
                    e = exp_q.pop_front();
                    check_value("wb_rd_o", word_t'(wb_rd), word_t'(e.rd));
                    check_value("wb_data_o", wb_data, e.data);
                end
            end
        end
    end

    initial begin
        int        i;
        int        j;
        int        k;
        int        sel;
        logic [11:0] imm;
        reg_addr_t prev;
        reg_addr_t cur;
        instr_t    word;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        foreach (model[n]) model[n] = '0;
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;

        // registers start at zero, so xi + imm hands back the immediate.
        for (i = 1; i < 32; i++) begin
            issue(encode_i(12'(i * 97 - 1500), reg_addr_t'(i), 3'b000, reg_addr_t'(i)));
        end

        // edge operands go to x1..x5 and x0 gives the zero shift.
        issue(encode_u(20'h80000, 5'd1));               // 0x80000000.
        issue(encode_i(12'hfff, 5'd0, 3'b000, 5'd2));   // all ones.
        issue(encode_u(20'h80000, 5'd3));
        issue(encode_i(12'hfff, 5'd3, 3'b000, 5'd3));   // 0x7fffffff via forwarding.
        issue(encode_i(12'd31, 5'd0, 3'b000, 5'd4));
        issue(encode_u(20'h12345, 5'd5));
        issue(encode_i(12'h678, 5'd5, 3'b000, 5'd5));
        for (i = 0; i < 6; i++) begin
            for (j = 0; j < 6; j++) begin
                for (k = 0; k < 10; k++) begin           // k 8 and 9 are sub and sra.
                    issue(encode_r((k < 8) ? 7'h00 : 7'h20, reg_addr_t'(j), reg_addr_t'(i),
                                   (k < 8) ? 3'(k) : ((k == 8) ? 3'b000 : 3'b101),
                                   reg_addr_t'(20 + k)));
                end
                for (k = 0; k < 9; k++) begin            // k 8 is srai.
                    imm = imm_set[j];
                    if (k == 1 || k == 5) imm = {7'h00, imm[4:0]};
                    if (k == 8) imm = {7'h20, imm[4:0]};
                    issue(encode_i(imm, reg_addr_t'(i), (k == 8) ? 3'b101 : 3'(k),
                                   reg_addr_t'(20 + k)));
                end
            end
        end
        issue(encode_u(20'hfffff, 5'd21));
        issue(encode_u(20'h00001, 5'd22));

        // gapless dependency chain reading the last rd on rs1, rs2 or both.
        issue(encode_i(12'h135, 5'd0, 3'b000, 5'd10));
        for (i = 0; i < 24; i++) begin
            prev = reg_addr_t'(10 + i % 8);
            cur  = reg_addr_t'(10 + (i + 1) % 8);
            if (i % 5 == 4) issue(encode_i(12'h0a5, prev, 3'b000, cur));
            else if (i % 3 == 0) issue(encode_r(7'h00, prev, prev, 3'b000, cur));
            else if (i % 3 == 1) issue(encode_r(7'h00, 5'd5, prev, 3'b100, cur));
            else issue(encode_r(7'h20, prev, 5'd5, 3'b000, cur));
        end

        // x0 writes are reported but never stored or forwarded.
        issue(encode_i(12'h07b, 5'd0, 3'b000, 5'd0));
        issue(encode_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd11));
        idle(2);
        issue(encode_r(7'h00, 5'd0, 5'd0, 3'b110, 5'd12));

        // unsupported opcodes aimed at x6 must leave it alone.
        issue(encode_i(12'h055, 5'd0, 3'b000, 5'd6));
        issue({12'h3ff, 5'd6, 3'b000, 5'd6, 7'b0000011});
        issue({12'h001, 5'd6, 3'b001, 5'd6, 7'b1100011});
        issue({25'h1ffffff, 7'b1111111});
        issue(encode_r(7'h00, 5'd0, 5'd6, 3'b000, 5'd13));

        // random mix of legal and illegal words with short idle gaps.
        for (i = 0; i < 300; i++) begin
            sel  = ($random(seed) & 32'h7fffffff) % 20;
            word = $random(seed);
            if (sel < 8) word[6:0] = OPCODE_OP;
            else if (sel < 15) word[6:0] = OPCODE_OP_IMM;
            else if (sel < 17) word[6:0] = OPCODE_LUI;
            else if (word[6:0] == OPCODE_OP || word[6:0] == OPCODE_OP_IMM ||
                     word[6:0] == OPCODE_LUI) word[6:0] = 7'b0001111;   // fence.
            issue(word);
            idle(($random(seed) & 32'h7fffffff) % 3);
        end

        // the last report lands two edges after its issue.
        idle(4);
        if (exp_q.size() != 0) begin
            $display("%0d write reports never arrived", exp_q.size());
            stop_run();
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* project.f */
hdl/rs5_pkg.sv
hdl/exec_if.sv
hdl/regbank.sv
hdl/decoder.sv
hdl/execute.sv
hdl/rs5_exec_top.sv
verif/rs5_exec_asserts.sv
verif/tb_rs5_exec.sv

/* Makefile */
# Verilator build and run for the rv32i execute slice.

TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP      := tb_rs5_exec
FILELIST := project.f
OBJ_DIR  := obj_dir
PASS_MSG := Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check for a pass"
	@echo "  clean  remove the build directory"

# the run passes only if the pass line shows up in the output.
test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
